// ==== btb_macros.svh ====
////////////////////////////////////////////////////////////
// BTB size macros
// PC, index, tag and target widths for the direct-mapped
// branch target buffer, plus the allocation counter value
////////////////////////////////////////////////////////////

`ifndef BTB_MACROS_SVH
`define BTB_MACROS_SVH

// Width of a fetch PC in bits
`define BTB_PC_W        32

// Number of BTB entries, one per index
`define BTB_DEPTH       64

// The index is PC bits 7 down to 2 and the tag is PC bits 31 down to 8
`define BTB_IDX_W       6
`define BTB_TAG_W       24

// Stored target is a word address and the low two bits are implied zero
`define BTB_TGT_W       30

// A taken branch that missed is allocated weakly taken
`define BTB_CTR_WEAK_T  2'b10

`endif

// ==== btb_pkg.sv ====
////////////////////////////////////////////////////////////
// BTB types
// RAM entry, lookup result and branch update words
////////////////////////////////////////////////////////////

`default_nettype none

`include "btb_macros.svh"

package btb_pkg;

        // Two bit saturating direction counter whose upper bit predicts taken
        typedef logic [1:0] btb_ctr_t;

        // One 57 bit RAM word with valid at the top
        typedef struct packed {
                logic                   valid;
                logic [`BTB_TAG_W-1:0]  tag;
                logic [`BTB_TGT_W-1:0]  target;
                btb_ctr_t               ctr;
        } btb_entry_t;

        // Lookup result returned one cycle after the fetch PC
        typedef struct packed {
                logic                   hit;
                logic                   taken;
                logic [`BTB_TGT_W-1:0]  target;
                btb_ctr_t               ctr;
        } btb_pred_t;

        // Resolved branch sent back by the execute stage
        typedef struct packed {
                logic [`BTB_PC_W-1:0]   pc;
                logic [`BTB_TGT_W-1:0]  target;
                logic                   taken;
                logic                   hit;
        } btb_upd_t;

endpackage

`default_nettype wire

// ==== btb_ram.sv ====
////////////////////////////////////////////////////////////
// BTB storage RAM
// One read and one write port, one cycle read latency,
// write data forwarded on a same-address collision
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module btb_ram #(
        parameter bit [31:0] WIDTH = 32'd57,
        parameter bit [31:0] DEPTH = 32'd64
)
(
        input  logic                            i_clk,

        // Write and read strobes
        input  logic                            i_wr_en,
        input  logic                            i_rd_en,

        // Write port
        input  logic [WIDTH-1:0]                i_wr_data,
        input  logic [$clog2(DEPTH)-1:0]        i_wr_addr,

        // Read port
        input  logic [$clog2(DEPTH)-1:0]        i_rd_addr,
        output logic [WIDTH-1:0]                o_rd_data
);

////////////////////////////////////////////////////////////
// Read-first array
////////////////////////////////////////////////////////////

logic [WIDTH-1:0] mem [DEPTH-1:0];
logic [WIDTH-1:0] mem_rd_data;

// The array returns the old word when both ports hit one address
always_ff @(posedge i_clk)
begin
        if (i_rd_en)
        begin
                mem_rd_data <= mem[i_rd_addr];
        end
        if (i_wr_en)
        begin
                mem[i_wr_addr] <= i_wr_data;
        end
end

////////////////////////////////////////////////////////////
// Same-address forwarding
////////////////////////////////////////////////////////////

logic             hazard_nxt;
logic             hazard_ff;
logic [WIDTH-1:0] buffer_ff;

// A read and a write to one address in the same cycle is a hazard
assign hazard_nxt = i_wr_en & i_rd_en & (i_wr_addr == i_rd_addr);

// Keep the write data so the next cycle can return it instead of the stale word
always_ff @(posedge i_clk)
begin
        hazard_ff <= hazard_nxt;
        if (hazard_nxt)
        begin
                buffer_ff <= i_wr_data;
        end
end

// This makes the array behave as write-first
assign o_rd_data = hazard_ff ? buffer_ff : mem_rd_data;

endmodule

`default_nettype wire

// ==== btb_lookup.sv ====
////////////////////////////////////////////////////////////
// BTB lookup
// Reads the entry for a fetch PC and forms the hit, the
// predicted direction and the target one cycle later
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "btb_macros.svh"

module btb_lookup
(
        input  logic                            i_clk,
        input  logic                            i_arst_n,

        // Fetch side
        input  logic                            i_lookup_valid,
        input  logic [`BTB_PC_W-1:0]            i_lookup_pc,

        // Level from the update block while the sweep runs
        input  logic                            i_sweeping,

        // RAM read port
        output logic                            o_rd_en,
        output logic [`BTB_IDX_W-1:0]           o_rd_addr,
        input  btb_pkg::btb_entry_t             i_rd_data,

        // Prediction
        output logic                            o_pred_valid,
        output btb_pkg::btb_pred_t              o_pred
);

import btb_pkg::*;

logic                   pred_valid_ff;
logic                   sweeping_ff;
logic [`BTB_TAG_W-1:0]  tag_ff;
btb_pred_t              pred_nxt;

////////////////////////////////////////////////////////////
// Read stage
////////////////////////////////////////////////////////////

// The index comes from PC bits 7 down to 2
assign o_rd_en   = i_lookup_valid;
assign o_rd_addr = i_lookup_pc[`BTB_IDX_W+1:2];

// Strobe and sweep level move alongside the RAM stage
always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
        begin
                pred_valid_ff <= 1'b0;
                sweeping_ff   <= 1'b1;
        end
        else
        begin
                pred_valid_ff <= i_lookup_valid;
                sweeping_ff   <= i_sweeping;
        end
end

// The tag of the looked up PC is compared against the stored tag next cycle
always_ff @(posedge i_clk)
begin
        if (i_lookup_valid)
        begin
                tag_ff <= i_lookup_pc[`BTB_PC_W-1:`BTB_IDX_W+2];
        end
end

////////////////////////////////////////////////////////////
// Prediction stage
////////////////////////////////////////////////////////////

always_comb
begin
        // Entries are not trusted until the sweep has cleared them all
        pred_nxt.hit    = i_rd_data.valid & (i_rd_data.tag == tag_ff) & ~sweeping_ff;
        pred_nxt.taken  = pred_nxt.hit & i_rd_data.ctr[1];
        pred_nxt.target = i_rd_data.target;
        pred_nxt.ctr    = i_rd_data.ctr;
end

assign o_pred_valid = pred_valid_ff;
assign o_pred       = pred_nxt;

endmodule

`default_nettype wire

// ==== btb_update.sv ====
////////////////////////////////////////////////////////////
// BTB update
// Clears every entry after reset, then turns resolved
// branches into RAM writes with the counter rule applied
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "btb_macros.svh"

module btb_update
(
        input  logic                            i_clk,
        input  logic                            i_arst_n,

        // Resolved branch
        input  logic                            i_upd_valid,
        input  btb_pkg::btb_upd_t               i_upd,

        // RAM write port
        output logic                            o_wr_en,
        output logic [`BTB_IDX_W-1:0]           o_wr_addr,
        output btb_pkg::btb_entry_t             o_wr_data,

        // Status
        output logic                            o_sweeping,
        output logic                            o_ready
);

import btb_pkg::*;

logic                   sweep_ff;
logic [`BTB_IDX_W-1:0]  sweep_idx_ff;
logic [`BTB_IDX_W-1:0]  upd_idx;
logic [`BTB_TAG_W-1:0]  upd_tag;
logic                   upd_write;
btb_ctr_t               ctr_prior;
btb_ctr_t               ctr_new;
btb_entry_t             upd_entry;

// Moves a counter one step toward the outcome and stops at 00 and 11
function automatic btb_ctr_t ctr_step(input btb_ctr_t ctr, input logic up);
        btb_ctr_t nxt;
        nxt = ctr;
        if (up && ctr != 2'b11)
        begin
                nxt = ctr + 2'b01;
        end
        else if (!up && ctr != 2'b00)
        begin
                nxt = ctr - 2'b01;
        end
        return nxt;
endfunction

////////////////////////////////////////////////////////////
// Invalidation sweep
////////////////////////////////////////////////////////////

// One index is written per cycle from 0 upward and the flag drops after the last
always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
        begin
                sweep_ff     <= 1'b1;
                sweep_idx_ff <= '0;
        end
        else if (sweep_ff)
        begin
                sweep_idx_ff <= sweep_idx_ff + 1'b1;
                if (sweep_idx_ff == `BTB_IDX_W'(`BTB_DEPTH - 1))
                begin
                        sweep_ff <= 1'b0;
                end
        end
end

////////////////////////////////////////////////////////////
// Update rule
////////////////////////////////////////////////////////////

always_comb
begin
        upd_idx   = i_upd.pc[`BTB_IDX_W+1:2];
        upd_tag   = i_upd.pc[`BTB_PC_W-1:`BTB_IDX_W+2];

        // The old counter is not returned, so the step starts at the weak state
        // on the outcome's side, 10 for taken and 01 for not taken
        ctr_prior = i_upd.taken ? `BTB_CTR_WEAK_T : 2'b01;
        ctr_new   = i_upd.hit ? ctr_step(ctr_prior, i_upd.taken) : `BTB_CTR_WEAK_T;

        // A not-taken branch that missed leaves the entry alone
        upd_write = i_upd_valid & (i_upd.hit | i_upd.taken);

        upd_entry.valid  = 1'b1;
        upd_entry.tag    = upd_tag;
        upd_entry.target = i_upd.target;
        upd_entry.ctr    = ctr_new;
end

// Updates arriving during the sweep are dropped
assign o_wr_en    = sweep_ff | upd_write;
assign o_wr_addr  = sweep_ff ? sweep_idx_ff : upd_idx;
assign o_wr_data  = sweep_ff ? btb_entry_t'('0) : upd_entry;

assign o_sweeping = sweep_ff;
assign o_ready    = ~sweep_ff;

endmodule

`default_nettype wire

// ==== btb_top.sv ====
////////////////////////////////////////////////////////////
// BTB top level
// Connects the storage RAM to the lookup and update blocks
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "btb_macros.svh"

module btb_top
(
        input  logic                            i_clk,
        input  logic                            i_arst_n,

        // Lookup from fetch
        input  logic                            i_lookup_valid,
        input  logic [`BTB_PC_W-1:0]            i_lookup_pc,
        output logic                            o_pred_valid,
        output btb_pkg::btb_pred_t              o_pred,

        // Update from the branch resolver
        input  logic                            i_upd_valid,
        input  btb_pkg::btb_upd_t               i_upd,

        // High once every entry has been cleared
        output logic                            o_ready
);

import btb_pkg::*;

// RAM port wiring
logic                   rd_en;
logic [`BTB_IDX_W-1:0]  rd_addr;
btb_entry_t             rd_data;
logic                   wr_en;
logic [`BTB_IDX_W-1:0]  wr_addr;
btb_entry_t             wr_data;
logic                   sweeping;

btb_ram #(
        .WIDTH  ($bits(btb_entry_t)),
        .DEPTH  (`BTB_DEPTH)
) u_ram (
        .i_clk          (i_clk),
        .i_wr_en        (wr_en),
        .i_rd_en        (rd_en),
        .i_wr_data      (wr_data),
        .i_wr_addr      (wr_addr),
        .i_rd_addr      (rd_addr),
        .o_rd_data      (rd_data)
);

btb_lookup u_lookup (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_lookup_valid (i_lookup_valid),
        .i_lookup_pc    (i_lookup_pc),
        .i_sweeping     (sweeping),
        .o_rd_en        (rd_en),
        .o_rd_addr      (rd_addr),
        .i_rd_data      (rd_data),
        .o_pred_valid   (o_pred_valid),
        .o_pred         (o_pred)
);

btb_update u_update (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_upd_valid    (i_upd_valid),
        .i_upd          (i_upd),
        .o_wr_en        (wr_en),
        .o_wr_addr      (wr_addr),
        .o_wr_data      (wr_data),
        .o_sweeping     (sweeping),
        .o_ready        (o_ready)
);

endmodule

`default_nettype wire

// ==== btb_tb_sva.sv ====
////////////////////////////////////////////////////////////
// BTB timing assertions
// Strobe latency, hit gating and ready behavior of the top
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module btb_tb_sva
(
        input  logic                    i_clk,
        input  logic                    i_arst_n,
        input  logic                    i_lookup_valid,
        input  logic                    i_pred_valid,
        input  btb_pkg::btb_pred_t      i_pred,
        input  logic                    i_ready
);

// A lookup strobe is answered on the very next edge and only then
a_pred_follows: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_lookup_valid |=> i_pred_valid)
        else $error("Lookup strobe was not answered one cycle later");

a_pred_quiet: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !i_lookup_valid |=> !i_pred_valid)
        else $error("Prediction strobe appeared without a lookup");

// Entries are not trusted while the sweep is still running
a_no_hit_early: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_pred_valid && i_pred.hit) |-> i_ready)
        else $error("Hit reported before the sweep completed");

// Ready only drops again through a reset
a_ready_stays: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_ready |=> i_ready)
        else $error("Ready fell after it was set");

endmodule

bind btb_top btb_tb_sva u_sva (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_lookup_valid (i_lookup_valid),
        .i_pred_valid   (o_pred_valid),
        .i_pred         (o_pred),
        .i_ready        (o_ready)
);

`default_nettype wire

// ==== btb_tb.sv ====
////////////////////////////////////////////////////////////
// BTB testbench
// Directed and random lookups and updates, each checked
// against a reference model of the entry array
////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "btb_macros.svh"

module btb_tb;

import btb_pkg::*;

// The watchdog adds up the cycle budget of each test
localparam int CLK_PERIOD   = 20;
localparam int CYC_RESET    = 10;
localparam int CYC_SWEEP    = 2 * `BTB_DEPTH + 2;
localparam int CYC_DIRECTED = 60;
localparam int CYC_RANDOM   = 300;
localparam int WATCHDOG_NS  = (CYC_RESET + CYC_SWEEP + CYC_DIRECTED + CYC_RANDOM) * CLK_PERIOD
                              + 2000;

logic                   clk;
logic                   arst_n;
logic                   lookup_valid;
logic [`BTB_PC_W-1:0]   lookup_pc;
logic                   pred_valid;
btb_pred_t              pred;
logic                   upd_valid;
btb_upd_t               upd_in;
logic                   ready;

// Reference array and bookkeeping
btb_entry_t             model [`BTB_DEPTH];
int                     cycles_since_reset;
integer                 seed;
btb_pred_t              last_pred;

btb_top UUT (
        .i_clk          (clk),
        .i_arst_n       (arst_n),
        .i_lookup_valid (lookup_valid),
        .i_lookup_pc    (lookup_pc),
        .o_pred_valid   (pred_valid),
        .o_pred         (pred),
        .i_upd_valid    (upd_valid),
        .i_upd          (upd_in),
        .o_ready        (ready)
);

initial
begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
end

initial
begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests completed, the DUT seems stuck");
        $display("Finished with errors");
        $fatal(1, "Timeout");
end

////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////

function automatic logic [`BTB_PC_W-1:0] make_pc(input logic [`BTB_TAG_W-1:0] tag,
                                                  input logic [`BTB_IDX_W-1:0] idx);
        return {tag, idx, 2'b00};
endfunction

function automatic btb_pred_t make_pred(input logic hit, input logic taken,
                                        input logic [`BTB_TGT_W-1:0] target, input btb_ctr_t ctr);
        btb_pred_t p;
        p.hit    = hit;
        p.taken  = taken;
        p.target = target;
        p.ctr    = ctr;
        return p;
endfunction

function automatic btb_upd_t make_upd(input logic [`BTB_PC_W-1:0] pc,
                                      input logic [`BTB_TGT_W-1:0] target,
                                      input logic taken, input logic hit);
        btb_upd_t u;
        u.pc     = pc;
        u.target = target;
        u.taken  = taken;
        u.hit    = hit;
        return u;
endfunction

// The sweep writes one index per edge, so it has ended after BTB_DEPTH edges
function automatic logic sweep_done();
        return cycles_since_reset >= `BTB_DEPTH;
endfunction

function automatic btb_pred_t model_predict(input logic [`BTB_PC_W-1:0] pc);
        btb_entry_t e;
        logic       hit;
        e   = model[pc[`BTB_IDX_W+1:2]];
        hit = sweep_done() && e.valid && (e.tag == pc[`BTB_PC_W-1:`BTB_IDX_W+2]);
        return make_pred(hit, hit && e.ctr[1], e.target, e.ctr);
endfunction

// A hit steps from the weak state on the outcome's side, so it lands on 11 or 00
task automatic model_update(input btb_upd_t u);
        btb_entry_t e;
        e.valid  = 1'b1;
        e.tag    = u.pc[`BTB_PC_W-1:`BTB_IDX_W+2];
        e.target = u.target;
        e.ctr    = u.hit ? (u.taken ? 2'b11 : 2'b00) : 2'b10;
        if (sweep_done() && (u.hit || u.taken))
        begin
                model[u.pc[`BTB_IDX_W+1:2]] = e;
        end
endtask

////////////////////////////////////////////////////////////
// Checks and cycle driver
////////////////////////////////////////////////////////////

task automatic report_error(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "Stopped at the first mismatch");
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
                report_error($sformatf("%s is %b, expected %b", what, got, exp));
        end
endtask

// On a miss only hit and taken carry meaning
task automatic check_pred(input btb_pred_t got, input btb_pred_t exp, input string what);
        if (got.hit !== exp.hit || got.taken !== exp.taken ||
            (exp.hit && (got.target !== exp.target || got.ctr !== exp.ctr)))
        begin
                report_error($sformatf(
                        "%s: got hit %b taken %b target %h ctr %b, expected %b %b %h %b",
                        what, got.hit, got.taken, got.target, got.ctr,
                        exp.hit, exp.taken, exp.target, exp.ctr));
        end
endtask

// Runs one clock cycle that is entered and left on a falling edge
task automatic drive_cycle(input logic lv, input logic [`BTB_PC_W-1:0] lpc,
                           input logic uv, input btb_upd_t u);
        btb_pred_t exp;
        exp          = '0;
        lookup_valid = lv;
        lookup_pc    = lpc;
        upd_valid    = uv;
        upd_in       = u;
        // Write first, so a same-index lookup sees the new entry
        if (uv)
        begin
                model_update(u);
        end
        if (lv)
        begin
                exp = model_predict(lpc);
        end
        @(posedge clk);
        cycles_since_reset++;
        @(negedge clk);
        check_bit(ready, sweep_done(), "o_ready");
        check_bit(pred_valid, lv, "o_pred_valid");
        if (lv)
        begin
                check_pred(pred, exp, "Prediction against model");
                last_pred = pred;
        end
endtask

task automatic lookup(input logic [`BTB_PC_W-1:0] pc);
        drive_cycle(1'b1, pc, 1'b0, '0);
endtask

task automatic update_then_lookup(input btb_upd_t u, input btb_pred_t exp, input string what);
        drive_cycle(1'b0, '0, 1'b1, u);
        lookup(u.pc);
        check_pred(last_pred, exp, what);
endtask

function automatic logic [`BTB_PC_W-1:0] random_pc();
        logic [31:0] r;
        r = $random(seed);
        // Four tags over eight indices keep hits and aliasing frequent
        return make_pc({22'd0, r[1:0]}, {3'd0, r[4:2]});
endfunction

////////////////////////////////////////////////////////////
// Tests
////////////////////////////////////////////////////////////

task automatic test_reset_sweep();
        int i;
        // Lookups during the sweep while o_ready is checked every cycle
        for (i = 0; i < `BTB_DEPTH; i++)
        begin
                lookup(random_pc());
        end
        for (i = 0; i < `BTB_DEPTH; i++)
        begin
                lookup(make_pc(`BTB_TAG_W'($random(seed)), `BTB_IDX_W'(i)));
                check_bit(last_pred.hit, 1'b0, "Hit after sweep");
        end
endtask

task automatic test_counters(input logic [`BTB_PC_W-1:0] pc_a,
                             input logic [`BTB_TGT_W-1:0] tgt_a);
        lookup(pc_a);
        update_then_lookup(make_upd(pc_a, tgt_a, 1'b1, 1'b0),
                           make_pred(1'b1, 1'b1, tgt_a, 2'b10),
                           "Allocate on taken miss");
        update_then_lookup(make_upd(pc_a, tgt_a, 1'b1, 1'b1),
                           make_pred(1'b1, 1'b1, tgt_a, 2'b11),
                           "Taken hit");
        update_then_lookup(make_upd(pc_a, tgt_a, 1'b1, 1'b1),
                           make_pred(1'b1, 1'b1, tgt_a, 2'b11),
                           "Taken hit saturates");
        update_then_lookup(make_upd(pc_a, tgt_a, 1'b0, 1'b1),
                           make_pred(1'b1, 1'b0, tgt_a, 2'b00),
                           "Not-taken hit");
        update_then_lookup(make_upd(pc_a, tgt_a, 1'b0, 1'b1),
                           make_pred(1'b1, 1'b0, tgt_a, 2'b00),
                           "Not-taken hit saturates");
        update_then_lookup(make_upd(pc_a, tgt_a, 1'b1, 1'b1),
                           make_pred(1'b1, 1'b1, tgt_a, 2'b11),
                           "Taken hit after not taken");
endtask

task automatic test_alias(input logic [`BTB_PC_W-1:0] pc_a,
                          input logic [`BTB_TGT_W-1:0] tgt_a);
        logic [`BTB_PC_W-1:0]  pc_b;
        logic [`BTB_TGT_W-1:0] tgt_b;
        pc_b  = make_pc(24'h65_4321, pc_a[`BTB_IDX_W+1:2]);
        tgt_b = 30'h1234_5678;
        lookup(pc_b);
        check_pred(last_pred, make_pred(1'b0, 1'b0, '0, '0), "Alias lookup");
        // Not-taken miss leaves the resident entry as it was
        update_then_lookup(make_upd(pc_b, tgt_b, 1'b0, 1'b0),
                           make_pred(1'b0, 1'b0, '0, '0),
                           "Not-taken miss writes nothing");
        lookup(pc_a);
        check_pred(last_pred, make_pred(1'b1, 1'b1, tgt_a, 2'b11), "Resident entry kept");
        update_then_lookup(make_upd(pc_b, tgt_b, 1'b1, 1'b0),
                           make_pred(1'b1, 1'b1, tgt_b, 2'b10),
                           "Alias replaces entry");
        lookup(pc_a);
        check_pred(last_pred, make_pred(1'b0, 1'b0, '0, '0), "Replaced PC misses");
endtask

task automatic test_collision();
        logic [`BTB_PC_W-1:0]  pc_c;
        logic [`BTB_TGT_W-1:0] tgt_c;
        pc_c  = make_pc(24'h0f_0f0f, 6'd40);
        tgt_c = 30'h2aaa_5555;
        drive_cycle(1'b1, pc_c, 1'b1, make_upd(pc_c, tgt_c, 1'b1, 1'b0));
        check_pred(last_pred, make_pred(1'b1, 1'b1, tgt_c, 2'b10), "Collision allocate");
        drive_cycle(1'b1, pc_c, 1'b1, make_upd(pc_c, tgt_c, 1'b0, 1'b1));
        check_pred(last_pred, make_pred(1'b1, 1'b0, tgt_c, 2'b00), "Collision counter step");
endtask

task automatic test_random();
        int                    n;
        logic                  lv;
        logic                  uv;
        logic                  taken;
        logic [`BTB_PC_W-1:0]  u_pc;
        btb_pred_t             p;
        for (n = 0; n < CYC_RANDOM; n++)
        begin
                lv    = 1'($random(seed));
                uv    = 1'($random(seed));
                taken = 1'($random(seed));
                u_pc  = random_pc();
                // The resolver hands back what the BTB predicted for this branch
                p     = model_predict(u_pc);
                drive_cycle(lv, random_pc(), uv,
                            make_upd(u_pc, taken ? `BTB_TGT_W'($random(seed)) : p.target,
                                     taken, p.hit));
        end
endtask

initial
begin
        int i;
        seed               = 32'hbbf4_e446;
        cycles_since_reset = 0;
        last_pred          = '0;
        arst_n             = 1'b0;
        lookup_valid       = 1'b0;
        lookup_pc          = '0;
        upd_valid          = 1'b0;
        upd_in             = '0;
        for (i = 0; i < `BTB_DEPTH; i++)
        begin
                model[i] = '0;
        end
        repeat (CYC_RESET) @(negedge clk);
        check_bit(ready, 1'b0, "o_ready in reset");
        check_bit(pred_valid, 1'b0, "o_pred_valid in reset");
        arst_n = 1'b1;

        test_reset_sweep();
        test_counters(make_pc(24'h12_3456, 6'd5), 30'h0abc_def0);
        test_alias(make_pc(24'h12_3456, 6'd5), 30'h0abc_def0);
        test_collision();
        test_random();
        drive_cycle(1'b0, '0, 1'b0, '0);

        $display("Finished with no errors");
        $finish;
end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
btb_pkg.sv
btb_ram.sv
btb_lookup.sv
btb_update.sv
btb_top.sv
btb_tb_sva.sv
btb_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the BTB testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module btb_tb -f files.f -o Vbtb_tb
if [ $? -ne 0 ]; then
        echo "Verilator build failed"
        exit 1
fi

./obj_dir/Vbtb_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
        echo "Simulation exited with status $sim_status"
fi

if grep -qx "Finished with no errors" "$LOG"; then
        if [ $sim_status -eq 0 ]; then
                echo "TEST PASSED"
                exit 0
        fi
fi

echo "TEST FAILED"
exit 1
